// File: Bender.yml
package:
  name: board_shell

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/board_shell_pkg.sv
      - source/mmio_target_if.sv
      - source/mmio_xbar_ctrl.sv
      - source/core_mmio_regs.sv
      - source/clkwiz_ctrl_regs.sv
      - source/core_reset_gen.sv
      - source/board_shell_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_board_shell.sv

// File: board_shell.f
+incdir+include
source/board_shell_pkg.sv
source/mmio_target_if.sv
source/mmio_xbar_ctrl.sv
source/core_mmio_regs.sv
source/clkwiz_ctrl_regs.sv
source/core_reset_gen.sv
source/board_shell_top.sv
verif/tb_board_shell.sv

// File: include/board_shell_consts.svh
`ifndef BOARD_SHELL_CONSTS_SVH
`define BOARD_SHELL_CONSTS_SVH

// host AXI-lite widths
`define BS_ADDR_W             32            // host byte address
`define BS_DATA_W             32            // register width
`define BS_STRB_W             4             // one strobe per byte lane
`define BS_OFFS_W             12            // offset inside a 4 KB window

// address map, one 4 KB window per target
`define BS_CORE_BASE          32'h0000_0000 // accelerator core MMIO
`define BS_CLKWIZ_BASE        32'h0001_0000 // clock wizard control

// core window layout
`define BS_SCRATCH_WORDS      8             // scratch at 0x00..0x1C
`define BS_CORE_DBG_OFFS      12'h020       // accepted write count, read only

// clock wizard window layout
`define BS_CW_CTRL_OFFS       12'h000       // bit0 clk_wiz_reset, bit1 core resetn
`define BS_CW_STATUS_OFFS     12'h004       // bit0 locked, bit1 fpga_top_resetn
`define BS_CW_LOSS_OFFS       12'h008       // lock-loss events

// synchronizer depths
`define BS_LOCK_SYNC_STAGES   2             // locked input sync
`define BS_RESET_SYNC_STAGES  4             // core reset release chain

`endif

// File: source/board_shell_pkg.sv
package board_shell_pkg;

  // crossbar controller, one access in flight
  typedef enum logic [2:0] {
    ST_IDLE    = 3'd0,  // host handshake window
    ST_FWD     = 3'd1,  // req_valid pulse to the selected target
    ST_WAIT    = 3'd2,  // target answers here
    ST_WR_RESP = 3'd3,  // b channel held until bready
    ST_RD_RESP = 3'd4   // r channel held until rready
  } xbar_state_e;

  // window hit by the captured address
  typedef enum logic [1:0] {
    SEL_CORE   = 2'd0,  // core MMIO window
    SEL_CLKWIZ = 2'd1,  // clock wizard control window
    SEL_NONE   = 2'd2   // unmapped, answered locally
  } target_sel_e;

  // AXI response codes, EXOKAY never produced
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,  // target rejected the offset
    RESP_DECERR = 2'd3   // no target at this address
  } axi_resp_e;

endpackage

// File: source/board_shell_top.sv
`timescale 1ns/1ps
`include "board_shell_consts.svh"

module board_shell_top import board_shell_pkg::*; (
  input  logic                  axi_aclk,
  input  logic                  arst_n,
  input  logic [`BS_ADDR_W-1:0] s_awaddr,
  input  logic                  s_awvalid,
  output logic                  s_awready,
  input  logic [`BS_DATA_W-1:0] s_wdata,
  input  logic [`BS_STRB_W-1:0] s_wstrb,
  input  logic                  s_wvalid,
  output logic                  s_wready,
  output axi_resp_e             s_bresp,
  output logic                  s_bvalid,
  input  logic                  s_bready,
  input  logic [`BS_ADDR_W-1:0] s_araddr,
  input  logic                  s_arvalid,
  output logic                  s_arready,
  output logic [`BS_DATA_W-1:0] s_rdata,
  output axi_resp_e             s_rresp,
  output logic                  s_rvalid,
  input  logic                  s_rready,
  input  logic                  clk_wiz_locked,
  output logic                  clk_wiz_reset,
  output logic                  fpga_top_resetn
);

  logic                  locked_sync;       // lock after the synchronizer
  logic                  core_ctrl_resetn;  // CTRL bit1
  logic [`BS_DATA_W-1:0] loss_count;

  mmio_target_if core_if ();
  mmio_target_if clkwiz_if ();

  mmio_xbar_ctrl xbar_i (
    .axi_aclk  (axi_aclk),
    .arst_n    (arst_n),
    .s_awaddr  (s_awaddr),
    .s_awvalid (s_awvalid),
    .s_awready (s_awready),
    .s_wdata   (s_wdata),
    .s_wstrb   (s_wstrb),
    .s_wvalid  (s_wvalid),
    .s_wready  (s_wready),
    .s_bresp   (s_bresp),
    .s_bvalid  (s_bvalid),
    .s_bready  (s_bready),
    .s_araddr  (s_araddr),
    .s_arvalid (s_arvalid),
    .s_arready (s_arready),
    .s_rdata   (s_rdata),
    .s_rresp   (s_rresp),
    .s_rvalid  (s_rvalid),
    .s_rready  (s_rready),
    .core_if   (core_if.ctrl),
    .clkwiz_if (clkwiz_if.ctrl)
  );

  core_mmio_regs core_regs_i (
    .axi_aclk (axi_aclk),
    .arst_n   (arst_n),
    .bus      (core_if.target)
  );

  clkwiz_ctrl_regs clkwiz_regs_i (
    .axi_aclk         (axi_aclk),
    .arst_n           (arst_n),
    .locked_sync      (locked_sync),
    .core_resetn      (fpga_top_resetn),  // reported in STATUS bit1
    .loss_count       (loss_count),
    .bus              (clkwiz_if.target),
    .clk_wiz_reset    (clk_wiz_reset),
    .core_ctrl_resetn (core_ctrl_resetn)
  );

  core_reset_gen reset_gen_i (
    .axi_aclk         (axi_aclk),
    .arst_n           (arst_n),
    .clk_wiz_locked   (clk_wiz_locked),
    .core_ctrl_resetn (core_ctrl_resetn),
    .locked_sync      (locked_sync),
    .fpga_top_resetn  (fpga_top_resetn),
    .loss_count       (loss_count)
  );

endmodule

// File: source/clkwiz_ctrl_regs.sv
`timescale 1ns/1ps
`include "board_shell_consts.svh"

module clkwiz_ctrl_regs import board_shell_pkg::*; (
  input  logic                  axi_aclk,
  input  logic                  arst_n,
  input  logic                  locked_sync,
  input  logic                  core_resetn,
  input  logic [`BS_DATA_W-1:0] loss_count,
  mmio_target_if.target         bus,
  output logic                  clk_wiz_reset,
  output logic                  core_ctrl_resetn
);

  logic [1:0]            ctrl_q;       // bit0 wizard reset and bit1 core resetn
  logic [`BS_DATA_W-1:0] rd_data;
  logic [`BS_DATA_W-1:0] rsp_rdata_q;
  logic                  rsp_valid_q;
  logic                  rsp_err_q;
  logic                  hit_ctrl;
  logic                  hit_status;
  logic                  hit_loss;
  logic                  ctrl_wr;

  assign hit_ctrl   = (bus.req_addr == `BS_CW_CTRL_OFFS);
  assign hit_status = (bus.req_addr == `BS_CW_STATUS_OFFS);
  assign hit_loss   = (bus.req_addr == `BS_CW_LOSS_OFFS);
  assign ctrl_wr    = bus.req_valid && bus.req_write && hit_ctrl && bus.req_wstrb[0];

  always_comb begin
    rd_data = '0;
    if (hit_ctrl) begin
      rd_data[1:0] = ctrl_q;
    end else if (hit_status) begin
      rd_data[1:0] = {core_resetn, locked_sync};  // live status without latching
    end else if (hit_loss) begin
      rd_data = loss_count;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (bus.req_valid) begin
      rsp_rdata_q <= rd_data;
    end
  end

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_q      <= 2'b00;  // wizard running and core held in reset
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
    end else begin
      rsp_valid_q <= bus.req_valid;
      if (ctrl_wr) begin
        ctrl_q <= bus.req_wdata[1:0];  // only byte lane 0 matters
      end
      if (bus.req_valid) begin
        if (bus.req_write) begin
          rsp_err_q <= !hit_ctrl;  // status and loss count are read only
        end else begin
          rsp_err_q <= !(hit_ctrl || hit_status || hit_loss);
        end
      end
    end
  end

  assign clk_wiz_reset    = ctrl_q[0];
  assign core_ctrl_resetn = ctrl_q[1];

  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp_rdata = rsp_rdata_q;
  assign bus.rsp_err   = rsp_err_q;

endmodule

// File: source/core_mmio_regs.sv
`timescale 1ns/1ps
`include "board_shell_consts.svh"

module core_mmio_regs import board_shell_pkg::*; (
  input  logic          axi_aclk,
  input  logic          arst_n,
  mmio_target_if.target bus
);

  localparam int IDX_W       = $clog2(`BS_SCRATCH_WORDS);
  localparam int SCRATCH_END = `BS_SCRATCH_WORDS * 4;  // first byte past scratch

  logic [`BS_DATA_W-1:0] scratch_q [`BS_SCRATCH_WORDS];
  logic [`BS_DATA_W-1:0] wr_cnt_q;     // debug counter of accepted writes
  logic [`BS_DATA_W-1:0] rsp_rdata_q;
  logic                  rsp_valid_q;
  logic                  rsp_err_q;
  logic [IDX_W-1:0]      idx;          // word select ignores the low two bits
  logic                  hit_scratch;
  logic                  hit_dbg;
  logic                  scratch_wr;

  assign idx         = bus.req_addr[IDX_W+1:2];
  assign hit_scratch = (bus.req_addr < SCRATCH_END);
  assign hit_dbg     = (bus.req_addr == `BS_CORE_DBG_OFFS);
  assign scratch_wr  = bus.req_valid && bus.req_write && hit_scratch;

  always_ff @(posedge axi_aclk) begin
    if (scratch_wr) begin
      for (int b = 0; b < `BS_STRB_W; b++) begin
        if (bus.req_wstrb[b]) begin  // byte lane merge
          scratch_q[idx][8*b +: 8] <= bus.req_wdata[8*b +: 8];
        end
      end
    end
    if (bus.req_valid) begin
      if (hit_scratch) begin
        rsp_rdata_q <= scratch_q[idx];  // old value on a write is dropped by ctrl
      end else if (hit_dbg) begin
        rsp_rdata_q <= wr_cnt_q;
      end else begin
        rsp_rdata_q <= '0;
      end
    end
  end

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
      wr_cnt_q    <= '0;
    end else begin
      rsp_valid_q <= bus.req_valid;  // fixed one-cycle answer
      if (bus.req_valid) begin
        if (bus.req_write) begin
          rsp_err_q <= !hit_scratch;  // counter is read only
        end else begin
          rsp_err_q <= !(hit_scratch || hit_dbg);
        end
      end
      if (scratch_wr) begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
      end
    end
  end

  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp_rdata = rsp_rdata_q;
  assign bus.rsp_err   = rsp_err_q;

endmodule

// File: source/core_reset_gen.sv
`timescale 1ns/1ps
`include "board_shell_consts.svh"

module core_reset_gen import board_shell_pkg::*; (
  input  logic                  axi_aclk,
  input  logic                  arst_n,
  input  logic                  clk_wiz_locked,    // async from the wizard
  input  logic                  core_ctrl_resetn,
  output logic                  locked_sync,
  output logic                  fpga_top_resetn,
  output logic [`BS_DATA_W-1:0] loss_count
);

  logic [`BS_LOCK_SYNC_STAGES-1:0]  lock_sync_q;
  logic                             locked_prev_q;  // edge detect on synced lock
  logic [`BS_RESET_SYNC_STAGES-1:0] release_q;      // ones shift in while released
  logic                             release_ok;

  assign locked_sync = lock_sync_q[`BS_LOCK_SYNC_STAGES-1];
  assign release_ok  = core_ctrl_resetn && locked_sync;

  // drops with release_ok and rises only after the chain fills
  assign fpga_top_resetn = release_q[`BS_RESET_SYNC_STAGES-1] && release_ok;

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      lock_sync_q   <= '0;
      locked_prev_q <= 1'b0;
      release_q     <= '0;
      loss_count    <= '0;
    end else begin
      lock_sync_q   <= {lock_sync_q[`BS_LOCK_SYNC_STAGES-2:0], clk_wiz_locked};
      locked_prev_q <= locked_sync;
      if (release_ok) begin
        release_q <= {release_q[`BS_RESET_SYNC_STAGES-2:0], 1'b1};
      end else begin
        release_q <= '0;  // restart the delay on any drop
      end
      if (locked_prev_q && !locked_sync) begin
        loss_count <= loss_count + 1'b1;  // lock lost
      end
    end
  end

endmodule

// File: source/mmio_target_if.sv
`timescale 1ns/1ps
`include "board_shell_consts.svh"

// one forwarded register access, targets always accept
interface mmio_target_if;

  logic                  req_valid;  // single-cycle pulse
  logic                  req_write;  // 1 write, 0 read
  logic [`BS_OFFS_W-1:0] req_addr;   // byte offset in window
  logic [`BS_DATA_W-1:0] req_wdata;
  logic [`BS_STRB_W-1:0] req_wstrb;

  logic                  rsp_valid;  // one cycle after req_valid
  logic [`BS_DATA_W-1:0] rsp_rdata;  // zero on error
  logic                  rsp_err;    // bad offset or read-only register

  modport ctrl (
    output req_valid, req_write, req_addr, req_wdata, req_wstrb,
    input  rsp_valid, rsp_rdata, rsp_err
  );

  modport target (
    input  req_valid, req_write, req_addr, req_wdata, req_wstrb,
    output rsp_valid, rsp_rdata, rsp_err
  );

endinterface

// File: source/mmio_xbar_ctrl.sv
`timescale 1ns/1ps
`include "board_shell_consts.svh"

module mmio_xbar_ctrl import board_shell_pkg::*; (
  input  logic                  axi_aclk,
  input  logic                  arst_n,
  input  logic [`BS_ADDR_W-1:0] s_awaddr,
  input  logic                  s_awvalid,
  output logic                  s_awready,
  input  logic [`BS_DATA_W-1:0] s_wdata,
  input  logic [`BS_STRB_W-1:0] s_wstrb,
  input  logic                  s_wvalid,
  output logic                  s_wready,
  output axi_resp_e             s_bresp,
  output logic                  s_bvalid,
  input  logic                  s_bready,
  input  logic [`BS_ADDR_W-1:0] s_araddr,
  input  logic                  s_arvalid,
  output logic                  s_arready,
  output logic [`BS_DATA_W-1:0] s_rdata,
  output axi_resp_e             s_rresp,
  output logic                  s_rvalid,
  input  logic                  s_rready,
  mmio_target_if.ctrl           core_if,
  mmio_target_if.ctrl           clkwiz_if
);

  localparam logic [`BS_ADDR_W-1:0] CORE_BASE   = `BS_CORE_BASE;
  localparam logic [`BS_ADDR_W-1:0] CLKWIZ_BASE = `BS_CLKWIZ_BASE;

  xbar_state_e           state_q;
  target_sel_e           sel_q;      // destination of the access in flight
  logic                  write_q;    // access in flight is a write
  logic [`BS_OFFS_W-1:0] offs_q;
  logic [`BS_DATA_W-1:0] wdata_q;
  logic [`BS_STRB_W-1:0] wstrb_q;
  logic [`BS_DATA_W-1:0] rdata_q;    // held on s_rdata during ST_RD_RESP
  axi_resp_e             resp_q;     // shared by b and r, only one is active

  logic                  wr_accept;
  logic                  rd_accept;
  logic [`BS_ADDR_W-1:0] acc_addr;
  target_sel_e           acc_sel;
  logic                  rsp_valid;  // muxed back from the selected target
  logic [`BS_DATA_W-1:0] rsp_rdata;
  logic                  rsp_err;

  // window match on the bits above the offset
  function automatic target_sel_e decode(input logic [`BS_ADDR_W-1:0] addr);
    target_sel_e sel;
    if (addr[`BS_ADDR_W-1:`BS_OFFS_W] == CORE_BASE[`BS_ADDR_W-1:`BS_OFFS_W]) begin
      sel = SEL_CORE;
    end else if (addr[`BS_ADDR_W-1:`BS_OFFS_W] == CLKWIZ_BASE[`BS_ADDR_W-1:`BS_OFFS_W]) begin
      sel = SEL_CLKWIZ;
    end else begin
      sel = SEL_NONE;
    end
    return sel;
  endfunction

  // aw and w taken together, write beats a pending read
  assign wr_accept = (state_q == ST_IDLE) && s_awvalid && s_wvalid;
  assign rd_accept = (state_q == ST_IDLE) && s_arvalid && !wr_accept;
  assign s_awready = wr_accept;
  assign s_wready  = wr_accept;
  assign s_arready = rd_accept;

  assign acc_addr = wr_accept ? s_awaddr : s_araddr;
  assign acc_sel  = decode(acc_addr);

  always_comb begin
    case (sel_q)
      SEL_CORE: begin
        rsp_valid = core_if.rsp_valid;
        rsp_rdata = core_if.rsp_rdata;
        rsp_err   = core_if.rsp_err;
      end
      SEL_CLKWIZ: begin
        rsp_valid = clkwiz_if.rsp_valid;
        rsp_rdata = clkwiz_if.rsp_rdata;
        rsp_err   = clkwiz_if.rsp_err;
      end
      default: begin  // unmapped never reaches ST_WAIT
        rsp_valid = 1'b0;
        rsp_rdata = '0;
        rsp_err   = 1'b0;
      end
    endcase
  end

  // same captured request to both targets, only the valid is steered
  assign core_if.req_valid   = (state_q == ST_FWD) && (sel_q == SEL_CORE);
  assign core_if.req_write   = write_q;
  assign core_if.req_addr    = offs_q;
  assign core_if.req_wdata   = wdata_q;
  assign core_if.req_wstrb   = wstrb_q;
  assign clkwiz_if.req_valid = (state_q == ST_FWD) && (sel_q == SEL_CLKWIZ);
  assign clkwiz_if.req_write = write_q;
  assign clkwiz_if.req_addr  = offs_q;
  assign clkwiz_if.req_wdata = wdata_q;
  assign clkwiz_if.req_wstrb = wstrb_q;

  assign s_bvalid = (state_q == ST_WR_RESP);
  assign s_bresp  = resp_q;
  assign s_rvalid = (state_q == ST_RD_RESP);
  assign s_rresp  = resp_q;
  assign s_rdata  = rdata_q;

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= ST_IDLE;
      sel_q   <= SEL_NONE;
      write_q <= 1'b0;
      resp_q  <= RESP_OKAY;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (wr_accept || rd_accept) begin
            sel_q   <= acc_sel;
            write_q <= wr_accept;
            if (acc_sel != SEL_NONE) begin
              state_q <= ST_FWD;
            end else if (wr_accept) begin  // decode error, skip the targets
              resp_q  <= RESP_DECERR;
              state_q <= ST_WR_RESP;
            end else begin
              resp_q  <= RESP_DECERR;
              state_q <= ST_RD_RESP;
            end
          end
        end
        ST_FWD: begin
          state_q <= ST_WAIT;
        end
        ST_WAIT: begin
          if (rsp_valid) begin
            if (rsp_err) begin
              resp_q <= RESP_SLVERR;
            end else begin
              resp_q <= RESP_OKAY;
            end
            if (write_q) begin
              state_q <= ST_WR_RESP;
            end else begin
              state_q <= ST_RD_RESP;
            end
          end
        end
        ST_WR_RESP: begin
          if (s_bready) begin  // stall here on back-pressure
            state_q <= ST_IDLE;
          end
        end
        ST_RD_RESP: begin
          if (s_rready) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (wr_accept || rd_accept) begin
      offs_q <= acc_addr[`BS_OFFS_W-1:0];  // window base dropped here
    end
    if (wr_accept) begin
      wdata_q <= s_wdata;
      wstrb_q <= s_wstrb;
    end
    if ((wr_accept || rd_accept) && (acc_sel == SEL_NONE)) begin
      rdata_q <= '0;  // DECERR returns zero data
    end else if ((state_q == ST_WAIT) && rsp_valid) begin
      rdata_q <= rsp_rdata;
    end
  end

endmodule

// File: verif/tb_board_shell.sv
`timescale 1ns/1ps
`include "board_shell_consts.svh"

module tb_board_shell;

  localparam logic [1:0] OKAY   = 2'd0;
  localparam logic [1:0] SLVERR = 2'd2;
  localparam logic [1:0] DECERR = 2'd3;
  localparam int NUM_TESTS      = 5;
  localparam int TXN_PER_TEST   = 32;  // upper bound over all tests
  localparam int TXN_CYCLES     = 24;  // handshake, target round trip and worst stall
  localparam int TIMEOUT_CYCLES = NUM_TESTS * TXN_PER_TEST * TXN_CYCLES;
  localparam int RELEASE_CYCLES = `BS_LOCK_SYNC_STAGES + `BS_RESET_SYNC_STAGES + 2;

  logic                  axi_aclk;
  logic                  arst_n;
  logic [`BS_ADDR_W-1:0] s_awaddr;
  logic                  s_awvalid;
  logic                  s_awready;
  logic [`BS_DATA_W-1:0] s_wdata;
  logic [`BS_STRB_W-1:0] s_wstrb;
  logic                  s_wvalid;
  logic                  s_wready;
  logic [1:0]            s_bresp;
  logic                  s_bvalid;
  logic                  s_bready;
  logic [`BS_ADDR_W-1:0] s_araddr;
  logic                  s_arvalid;
  logic                  s_arready;
  logic [`BS_DATA_W-1:0] s_rdata;
  logic [1:0]            s_rresp;
  logic                  s_rvalid;
  logic                  s_rready;
  logic                  clk_wiz_locked;
  logic                  clk_wiz_reset;
  logic                  fpga_top_resetn;

  integer      seed;
  int          bp_max;       // longest ready stall where 0 keeps ready high
  int          checks;
  int          errors;
  int          test_errors;  // error count when the current test started
  int          tests_run;
  int          cycle_cnt;
  string       cur_test;
  logic [31:0] scratch_model [`BS_SCRATCH_WORDS];
  int          wr_count;     // expected debug counter
  logic [1:0]  ctrl_model;

  board_shell_top dut_i (
    .axi_aclk        (axi_aclk),
    .arst_n          (arst_n),
    .s_awaddr        (s_awaddr),
    .s_awvalid       (s_awvalid),
    .s_awready       (s_awready),
    .s_wdata         (s_wdata),
    .s_wstrb         (s_wstrb),
    .s_wvalid        (s_wvalid),
    .s_wready        (s_wready),
    .s_bresp         (s_bresp),
    .s_bvalid        (s_bvalid),
    .s_bready        (s_bready),
    .s_araddr        (s_araddr),
    .s_arvalid       (s_arvalid),
    .s_arready       (s_arready),
    .s_rdata         (s_rdata),
    .s_rresp         (s_rresp),
    .s_rvalid        (s_rvalid),
    .s_rready        (s_rready),
    .clk_wiz_locked  (clk_wiz_locked),
    .clk_wiz_reset   (clk_wiz_reset),
    .fpga_top_resetn (fpga_top_resetn)
  );

  always #2 axi_aclk = ~axi_aclk;  // 4 ns period

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED %s %s: expected %h actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      $display("ERROR %s: %s", cur_test, what);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = errors;
    tests_run++;
  endtask

  task automatic end_test();
    $display("test %s done: %0d errors", cur_test, errors - test_errors);
  endtask

  // byte lanes with strobe set take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = nw[8*b +: 8];
      end
    end
    return res;
  endfunction

  // one AXI-lite access with ready held low for a random stall when bp_max > 0
  task automatic bus_access(input logic is_wr, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, output logic [31:0] rdata,
                            output logic [1:0] resp);
    int   stall;
    logic done;
    stall = (bp_max > 0) ? ($unsigned($random(seed)) % (bp_max + 1)) : 0;
    @(negedge axi_aclk);
    if (is_wr) begin
      s_awaddr  = addr;
      s_wdata   = wdata;
      s_wstrb   = strb;
      s_awvalid = 1'b1;
      s_wvalid  = 1'b1;
      s_bready  = (stall == 0);
    end else begin
      s_araddr  = addr;
      s_arvalid = 1'b1;
      s_rready  = (stall == 0);
    end
    done = 1'b0;
    while (!done) begin
      #1;  // mid low phase with inputs and ready settled
      done = is_wr ? (s_awready && s_wready) : s_arready;
      @(negedge axi_aclk);  // accepted on the posedge just passed
    end
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    s_arvalid = 1'b0;
    #1;
    while (!(is_wr ? s_bvalid : s_rvalid)) begin
      @(negedge axi_aclk);
      #1;
    end
    resp  = is_wr ? s_bresp : s_rresp;
    rdata = is_wr ? 32'h0 : s_rdata;
    for (int i = 0; i < stall; i++) begin
      @(negedge axi_aclk);
      #1;
      check_true(is_wr ? (s_bvalid && s_bresp === resp)
                       : (s_rvalid && s_rresp === resp && s_rdata === rdata),
                 "response dropped or changed while ready was low");
    end
    if (stall > 0) begin
      @(negedge axi_aclk);
      if (is_wr) begin
        s_bready = 1'b1;
      end else begin
        s_rready = 1'b1;
      end
    end
    @(negedge axi_aclk);  // response taken on the posedge just passed
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
    logic [31:0] unused;
    bus_access(1'b1, addr, data, strb, unused, resp);
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    bus_access(1'b0, addr, 32'h0, 4'h0, data, resp);
  endtask

  task automatic read_expect(input string what, input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic [1:0]  resp;
    axil_read(addr, rd, resp);
    check_value({what, " resp"}, OKAY, resp);
    check_value(what, exp, rd);
  endtask

  task automatic reset_state_test();
    start_test("reset_state");
    @(negedge axi_aclk);
    check_value("ready and valid outputs", 5'b0,
                {s_awready, s_wready, s_arready, s_bvalid, s_rvalid});
    check_value("clk_wiz_reset", 0, clk_wiz_reset);
    check_value("fpga_top_resetn", 0, fpga_top_resetn);
    read_expect("status", `BS_CLKWIZ_BASE + `BS_CW_STATUS_OFFS, 32'h1);  // locked with core held
    end_test();
  endtask

  task automatic scratch_test();
    logic [31:0] data;
    logic [3:0]  strb;
    logic [1:0]  resp;
    start_test("scratch_regs");
    for (int pass = 0; pass < 2; pass++) begin  // full words first and random strobes after
      for (int i = 0; i < `BS_SCRATCH_WORDS; i++) begin
        data = $random(seed);
        strb = (pass == 0) ? 4'hf : 4'($random(seed));
        axil_write(`BS_CORE_BASE + 4*i, data, strb, resp);
        check_value("scratch write resp", OKAY, resp);
        scratch_model[i] = merge_bytes(scratch_model[i], data, strb);
        wr_count++;
      end
    end
    for (int i = 0; i < `BS_SCRATCH_WORDS; i++) begin
      read_expect($sformatf("scratch[%0d]", i), `BS_CORE_BASE + 4*i, scratch_model[i]);
    end
    read_expect("debug write count", `BS_CORE_BASE + `BS_CORE_DBG_OFFS, wr_count);
    end_test();
  endtask

  task automatic reset_ctrl_test();
    logic [1:0]  resp;
    int          n;
    start_test("reset_ctrl");
    axil_write(`BS_CLKWIZ_BASE + `BS_CW_CTRL_OFFS, 32'h1, 4'h1, resp);
    check_value("ctrl write resp", OKAY, resp);
    check_value("clk_wiz_reset set", 1, clk_wiz_reset);
    axil_write(`BS_CLKWIZ_BASE + `BS_CW_CTRL_OFFS, 32'h0, 4'h1, resp);
    check_value("ctrl clear resp", OKAY, resp);
    check_value("clk_wiz_reset cleared", 0, clk_wiz_reset);
    read_expect("loss count before", `BS_CLKWIZ_BASE + `BS_CW_LOSS_OFFS, 32'h0);
    axil_write(`BS_CLKWIZ_BASE + `BS_CW_CTRL_OFFS, 32'h2, 4'h1, resp);  // release core
    check_value("ctrl release resp", OKAY, resp);
    ctrl_model = 2'b10;
    n = 0;
    while (!fpga_top_resetn && n < RELEASE_CYCLES) begin
      @(negedge axi_aclk);
      n++;
    end
    check_true(fpga_top_resetn, "fpga_top_resetn did not rise after the core reset bit was set");
    read_expect("status released", `BS_CLKWIZ_BASE + `BS_CW_STATUS_OFFS, 32'h3);
    @(negedge axi_aclk);
    clk_wiz_locked = 1'b0;  // wizard loses lock
    n = 0;
    while (fpga_top_resetn && n < `BS_LOCK_SYNC_STAGES + 2) begin
      @(negedge axi_aclk);
      n++;
    end
    check_true(!fpga_top_resetn, "fpga_top_resetn stayed high after locked dropped");
    read_expect("loss count after", `BS_CLKWIZ_BASE + `BS_CW_LOSS_OFFS, 32'h1);  // one drop
    read_expect("status unlocked", `BS_CLKWIZ_BASE + `BS_CW_STATUS_OFFS, 32'h0);
    @(negedge axi_aclk);
    clk_wiz_locked = 1'b1;
    n = 0;
    while (!fpga_top_resetn && n < RELEASE_CYCLES) begin
      @(negedge axi_aclk);
      n++;
    end
    check_true(fpga_top_resetn, "fpga_top_resetn did not return after lock came back");
    end_test();
  endtask

  task automatic error_resp_test();
    logic [31:0] rd;
    logic [1:0]  resp;
    start_test("error_resp");
    axil_read(32'h0002_0000, rd, resp);  // between and above the windows
    check_value("unmapped read resp", DECERR, resp);
    check_value("unmapped read data", 32'h0, rd);
    axil_write(32'h0003_0010, 32'hdead_beef, 4'hf, resp);
    check_value("unmapped write resp", DECERR, resp);
    axil_read(`BS_CORE_BASE + 12'h100, rd, resp);
    check_value("bad core offset read resp", SLVERR, resp);
    axil_write(`BS_CORE_BASE + 12'h100, 32'h1234_5678, 4'hf, resp);
    check_value("bad core offset write resp", SLVERR, resp);
    axil_write(`BS_CORE_BASE + `BS_CORE_DBG_OFFS, 32'h0, 4'hf, resp);
    check_value("debug count write resp", SLVERR, resp);
    axil_write(`BS_CLKWIZ_BASE + `BS_CW_STATUS_OFFS, 32'h0, 4'hf, resp);
    check_value("status write resp", SLVERR, resp);
    read_expect("ctrl kept", `BS_CLKWIZ_BASE + `BS_CW_CTRL_OFFS, ctrl_model);
    read_expect("debug count kept", `BS_CORE_BASE + `BS_CORE_DBG_OFFS, wr_count);
    for (int i = 0; i < `BS_SCRATCH_WORDS; i++) begin
      read_expect($sformatf("scratch[%0d] kept", i), `BS_CORE_BASE + 4*i, scratch_model[i]);
    end
    end_test();
  endtask

  task automatic backpressure_test();
    logic [31:0] data;
    logic [1:0]  resp;
    logic        ar_done;
    logic        b_seen;
    logic        r_seen;
    int          idx;
    start_test("backpressure");
    bp_max = 12;
    for (int i = 0; i < `BS_SCRATCH_WORDS; i++) begin
      data = $random(seed);
      axil_write(`BS_CORE_BASE + 4*i, data, 4'hf, resp);
      check_value("stalled write resp", OKAY, resp);
      scratch_model[i] = data;
      wr_count++;
    end
    for (int i = 0; i < `BS_SCRATCH_WORDS; i++) begin
      read_expect($sformatf("stalled read[%0d]", i), `BS_CORE_BASE + 4*i, scratch_model[i]);
    end
    bp_max = 0;
    // write and read to the same word presented together
    idx  = $unsigned($random(seed)) % `BS_SCRATCH_WORDS;
    data = $random(seed);
    @(negedge axi_aclk);
    s_awaddr  = `BS_CORE_BASE + 4*idx;
    s_wdata   = data;
    s_wstrb   = 4'hf;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    s_araddr  = `BS_CORE_BASE + 4*idx;
    s_arvalid = 1'b1;
    s_bready  = 1'b1;
    s_rready  = 1'b1;
    #1;
    check_true(s_awready && s_wready && !s_arready, "write was not taken ahead of the read");
    @(negedge axi_aclk);
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    scratch_model[idx] = data;
    wr_count++;
    b_seen = 1'b0;
    r_seen = 1'b0;
    while (!r_seen) begin
      #1;
      ar_done = s_arready;
      if (s_bvalid) begin
        b_seen = 1'b1;
        check_value("simultaneous write resp", OKAY, s_bresp);
      end
      if (s_rvalid) begin
        r_seen = 1'b1;
        check_true(b_seen, "read response came before the write response");
        check_value("simultaneous read data", data, s_rdata);
      end
      @(negedge axi_aclk);
      if (ar_done) begin
        s_arvalid = 1'b0;
      end
    end
    read_expect("debug count final", `BS_CORE_BASE + `BS_CORE_DBG_OFFS, wr_count);
    end_test();
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge axi_aclk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, a handshake never completed", cycle_cnt);
    $display("Checks failed");
    $finish;
  end

  initial begin
    seed           = 32'h58dc_1b62;
    axi_aclk       = 1'b0;
    arst_n         = 1'b0;
    s_awaddr       = '0;
    s_awvalid      = 1'b0;
    s_wdata        = '0;
    s_wstrb        = '0;
    s_wvalid       = 1'b0;
    s_bready       = 1'b0;
    s_araddr       = '0;
    s_arvalid      = 1'b0;
    s_rready       = 1'b0;
    clk_wiz_locked = 1'b1;  // wizard locked from power-up
    bp_max         = 0;
    checks         = 0;
    errors         = 0;
    tests_run      = 0;
    wr_count       = 0;
    ctrl_model     = 2'b00;
    repeat (10) @(negedge axi_aclk);
    arst_n = 1'b1;
    reset_state_test();
    scratch_test();
    reset_ctrl_test();
    error_resp_test();
    backpressure_test();
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
